// ==== logic/csr_pkg.sv ====
package csr_pkg;

    localparam int xlen = 32;

    typedef logic [11:0] csr_addr_t;
    typedef logic [1:0] priv_t;

    localparam priv_t priv_u = 2'd0;
    localparam priv_t priv_s = 2'd1;
    localparam priv_t priv_m = 2'd3;

    // encoding follows the funct3 low bits of csrrw/csrrs/csrrc
    typedef enum logic [1:0] {
        op_rw = 2'd1,
        op_rs = 2'd2,
        op_rc = 2'd3
    } csr_op_t;

    localparam csr_addr_t addr_sstatus  = 12'h100;
    localparam csr_addr_t addr_stvec    = 12'h105;
    localparam csr_addr_t addr_sscratch = 12'h140;
    localparam csr_addr_t addr_sepc     = 12'h141;
    localparam csr_addr_t addr_scause   = 12'h142;
    localparam csr_addr_t addr_mstatus  = 12'h300;
    localparam csr_addr_t addr_misa     = 12'h301;
    localparam csr_addr_t addr_medeleg  = 12'h302;
    localparam csr_addr_t addr_mtvec    = 12'h305;
    localparam csr_addr_t addr_mscratch = 12'h340;
    localparam csr_addr_t addr_mepc     = 12'h341;
    localparam csr_addr_t addr_mcause   = 12'h342;

    // sie, mie, spie, mpie, spp, mpp, tsr
    localparam logic [xlen-1:0] status_mask  = 32'h0040_19aa;
    localparam logic [xlen-1:0] sstatus_mask = 32'h0000_0122;
    localparam logic [xlen-1:0] tvec_mask    = 32'hffff_fffc;
    localparam logic [xlen-1:0] epc_mask     = 32'hffff_fffc;
    localparam logic [xlen-1:0] cause_mask   = 32'h0000_001f;
    localparam logic [xlen-1:0] medeleg_mask = 32'h0000_ffff;

    localparam logic [4:0] exc_illegal = 5'd2;
    localparam logic [4:0] exc_ecall   = 5'd8;
    // reserved codes, used only to mark returns
    localparam logic [4:0] exc_mret    = 5'd24;
    localparam logic [4:0] exc_sret    = 5'd25;

    typedef struct packed {
        logic [8:0] rsv_31;
        logic       tsr;
        logic [8:0] rsv_21;
        priv_t      mpp;
        logic [1:0] rsv_10;
        logic       spp;
        logic       mpie;
        logic       rsv_6;
        logic       spie;
        logic       rsv_4;
        logic       mie;
        logic       rsv_2;
        logic       sie;
        logic       rsv_0;
    } status_t;

    typedef union packed {
        logic [xlen-1:0] raw;
        status_t         st;
    } csr_word_u;

    typedef struct packed {
        csr_op_t         op;
        logic            use_imm;
        logic [4:0]      imm;
        logic [xlen-1:0] src;
        csr_addr_t       id;
    } csr_req_t;

    typedef struct packed {
        logic [xlen-1:0] rdata;
        logic            illegal;
    } csr_resp_t;

    typedef struct packed {
        logic [4:0]      code;
        logic [xlen-1:0] pc;
    } trap_req_t;

    typedef struct packed {
        csr_word_u       mstatus;
        logic [xlen-1:0] medeleg;
        logic [xlen-1:0] mtvec;
        logic [xlen-1:0] stvec;
        logic [xlen-1:0] mepc;
        logic [xlen-1:0] sepc;
    } trap_view_t;

    typedef enum logic [1:0] {
        act_none,
        act_enter,
        act_mret,
        act_sret
    } trap_act_t;

    typedef struct packed {
        trap_act_t       action;
        logic            to_s;
        priv_t           prev;
        logic [4:0]      cause;
        logic [xlen-1:0] epc;
    } trap_upd_t;

endpackage

// ==== logic/csr_access.sv ====
`timescale 1ns/10ps

module csr_access (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      csr_valid,
    input  csr_pkg::csr_req_t         csr_req,
    input  csr_pkg::priv_t            mode,
    input  logic [csr_pkg::xlen-1:0]  rd_data,
    input  logic                      rd_hit,
    output logic                      wr_en,
    output csr_pkg::csr_addr_t        wr_addr,
    output logic [csr_pkg::xlen-1:0]  wr_data,
    output logic                      resp_valid,
    output csr_pkg::csr_resp_t        resp
);
    import csr_pkg::*;

    logic [xlen-1:0] operand;
    logic            priv_low;
    logic            read_only;
    logic            writes;
    logic            illegal;

    assign operand = csr_req.use_imm ? {{(xlen-5){1'b0}}, csr_req.imm} : csr_req.src;

    // required privilege sits in id[9:8]
    assign priv_low = mode < csr_req.id[9:8];

    // misa is fixed in this hart and counts as read-only like the 11:10 space
    assign read_only = (csr_req.id[11:10] == 2'b11) || (csr_req.id == addr_misa);

    // set and clear with a zero operand only read
    always_comb begin
        case (csr_req.op)
            op_rw:        writes = 1'b1;
            op_rs, op_rc: writes = operand != '0;
            default:      writes = 1'b0;
        endcase
    end

    assign illegal = !rd_hit || priv_low || (read_only && writes);

    assign wr_en   = csr_valid && !illegal && writes;
    assign wr_addr = csr_req.id;

    // the register file applies the per-register mask
    always_comb begin
        case (csr_req.op)
            op_rw:   wr_data = operand;
            op_rs:   wr_data = rd_data | operand;
            op_rc:   wr_data = rd_data & ~operand;
            default: wr_data = rd_data;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= csr_valid;
        end
    end

    // old value goes back and a refused access returns zero
    always_ff @(posedge clk) begin
        if (csr_valid) begin
            resp.rdata   <= illegal ? '0 : rd_data;
            resp.illegal <= illegal;
        end
    end

endmodule

// ==== logic/csr_file.sv ====
`timescale 1ns/10ps

module csr_file #(
    parameter logic [csr_pkg::xlen-1:0] misa_value = 32'h4014_0100
) (
    input  logic                      clk,
    input  logic                      rst,
    input  csr_pkg::csr_addr_t        rd_addr,
    output logic [csr_pkg::xlen-1:0]  rd_data,
    output logic                      rd_hit,
    input  logic                      wr_en,
    input  csr_pkg::csr_addr_t        wr_addr,
    input  logic [csr_pkg::xlen-1:0]  wr_data,
    input  csr_pkg::trap_upd_t        trap_upd,
    output csr_pkg::trap_view_t       view
);
    import csr_pkg::*;

    csr_word_u       mstatus;
    logic [xlen-1:0] medeleg;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mscratch;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] stvec;
    logic [xlen-1:0] sscratch;
    logic [xlen-1:0] sepc;
    logic [xlen-1:0] scause;

    csr_word_u       status_next;

    always_comb begin
        rd_hit = 1'b1;
        case (rd_addr)
            addr_sstatus:  rd_data = mstatus.raw & sstatus_mask;
            addr_stvec:    rd_data = stvec;
            addr_sscratch: rd_data = sscratch;
            addr_sepc:     rd_data = sepc;
            addr_scause:   rd_data = scause;
            addr_mstatus:  rd_data = mstatus.raw;
            addr_misa:     rd_data = misa_value;
            addr_medeleg:  rd_data = medeleg;
            addr_mtvec:    rd_data = mtvec;
            addr_mscratch: rd_data = mscratch;
            addr_mepc:     rd_data = mepc;
            addr_mcause:   rd_data = mcause;
            default: begin
                rd_data = '0;
                rd_hit  = 1'b0;
            end
        endcase
    end

    // sstatus only touches its own bits and keeps the rest of mstatus
    always_comb begin
        if (wr_addr == addr_sstatus) begin
            status_next.raw = (mstatus.raw & ~sstatus_mask) | (wr_data & sstatus_mask);
        end else begin
            status_next.raw = wr_data & status_mask;
        end
        // mpp is WARL and never stores the reserved mode 2
        if (status_next.st.mpp == 2'b10) begin
            status_next.st.mpp = mstatus.st.mpp;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mstatus.raw <= '0;
            medeleg     <= '0;
            mtvec       <= '0;
            mscratch    <= '0;
            mepc        <= '0;
            mcause      <= '0;
            stvec       <= '0;
            sscratch    <= '0;
            sepc        <= '0;
            scause      <= '0;
        end else begin
            if (wr_en) begin
                case (wr_addr)
                    addr_mstatus, addr_sstatus: mstatus <= status_next;
                    addr_medeleg:  medeleg  <= wr_data & medeleg_mask;
                    addr_mtvec:    mtvec    <= wr_data & tvec_mask;
                    addr_mscratch: mscratch <= wr_data;
                    addr_mepc:     mepc     <= wr_data & epc_mask;
                    addr_mcause:   mcause   <= wr_data & cause_mask;
                    addr_stvec:    stvec    <= wr_data & tvec_mask;
                    addr_sscratch: sscratch <= wr_data;
                    addr_sepc:     sepc     <= wr_data & epc_mask;
                    addr_scause:   scause   <= wr_data & cause_mask;
                    default: ;
                endcase
            end

            case (trap_upd.action)
                act_enter: begin
                    if (trap_upd.to_s) begin
                        mstatus.st.spp  <= trap_upd.prev[0];
                        mstatus.st.spie <= mstatus.st.sie;
                        mstatus.st.sie  <= 1'b0;
                        sepc            <= trap_upd.epc & epc_mask;
                        scause          <= {{(xlen-5){1'b0}}, trap_upd.cause};
                    end else begin
                        mstatus.st.mpp  <= trap_upd.prev;
                        mstatus.st.mpie <= mstatus.st.mie;
                        mstatus.st.mie  <= 1'b0;
                        mepc            <= trap_upd.epc & epc_mask;
                        mcause          <= {{(xlen-5){1'b0}}, trap_upd.cause};
                    end
                end
                act_mret: begin
                    mstatus.st.mie  <= mstatus.st.mpie;
                    mstatus.st.mpie <= 1'b1;
                    mstatus.st.mpp  <= priv_u;
                end
                act_sret: begin
                    mstatus.st.sie  <= mstatus.st.spie;
                    mstatus.st.spie <= 1'b1;
                    mstatus.st.spp  <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    assign view.mstatus = mstatus;
    assign view.medeleg = medeleg;
    assign view.mtvec   = mtvec;
    assign view.stvec   = stvec;
    assign view.mepc    = mepc;
    assign view.sepc    = sepc;

endmodule

// ==== logic/trap_unit.sv ====
`timescale 1ns/10ps

module trap_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      trap_valid,
    input  csr_pkg::trap_req_t        trap_req,
    input  csr_pkg::trap_view_t       view,
    output csr_pkg::trap_upd_t        trap_upd,
    output logic                      redirect_valid,
    output logic [csr_pkg::xlen-1:0]  target_pc,
    output csr_pkg::priv_t            mode
);
    import csr_pkg::*;

    logic            is_mret;
    logic            is_sret;
    logic            ret_ok;
    logic [4:0]      cause;
    logic            delegate;
    priv_t           mode_next;
    logic [xlen-1:0] target_next;

    assign is_mret = trap_req.code == exc_mret;
    assign is_sret = trap_req.code == exc_sret;

    // tsr traps sret from S mode
    assign ret_ok = (is_mret && mode == priv_m) ||
                    (is_sret && (mode == priv_m ||
                                 (mode == priv_s && !view.mstatus.st.tsr)));

    always_comb begin
        if (trap_req.code == exc_ecall) begin
            cause = exc_ecall + {3'b000, mode};
        end else if ((is_mret || is_sret) && !ret_ok) begin
            cause = exc_illegal;
        end else begin
            cause = trap_req.code;
        end
    end

    // traps taken in M never go down to S
    assign delegate = view.medeleg[cause] && mode != priv_m;

    always_comb begin
        trap_upd.to_s  = delegate;
        trap_upd.prev  = mode;
        trap_upd.cause = cause;
        trap_upd.epc   = trap_req.pc;
        if (!trap_valid) begin
            trap_upd.action = act_none;
        end else if (ret_ok) begin
            trap_upd.action = is_mret ? act_mret : act_sret;
        end else begin
            trap_upd.action = act_enter;
        end
    end

    always_comb begin
        if (ret_ok && is_mret) begin
            mode_next   = view.mstatus.st.mpp;
            target_next = view.mepc;
        end else if (ret_ok) begin
            mode_next   = {1'b0, view.mstatus.st.spp};
            target_next = view.sepc;
        end else if (delegate) begin
            mode_next   = priv_s;
            target_next = view.stvec;
        end else begin
            mode_next   = priv_m;
            target_next = view.mtvec;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_valid <= 1'b0;
            mode           <= priv_m;
        end else begin
            redirect_valid <= trap_valid;
            if (trap_valid) begin
                mode <= mode_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trap_valid) begin
            target_pc <= target_next;
        end
    end

endmodule

// ==== logic/csr_top.sv ====
`timescale 1ns/10ps

module csr_top #(
    parameter logic [csr_pkg::xlen-1:0] misa_value = 32'h4014_0100
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      csr_valid,
    input  csr_pkg::csr_req_t         csr_req,
    input  logic                      trap_valid,
    input  csr_pkg::trap_req_t        trap_req,
    output logic                      resp_valid,
    output csr_pkg::csr_resp_t        resp,
    output logic                      redirect_valid,
    output logic [csr_pkg::xlen-1:0]  target_pc,
    output csr_pkg::priv_t            mode
);
    import csr_pkg::*;

    logic [xlen-1:0] rd_data;
    logic            rd_hit;
    logic            wr_en;
    csr_addr_t       wr_addr;
    logic [xlen-1:0] wr_data;
    trap_view_t      view;
    trap_upd_t       trap_upd;

    csr_access u_access (
        .clk        (clk),
        .rst        (rst),
        .csr_valid  (csr_valid),
        .csr_req    (csr_req),
        .mode       (mode),
        .rd_data    (rd_data),
        .rd_hit     (rd_hit),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    csr_file #(
        .misa_value (misa_value)
    ) u_file (
        .clk      (clk),
        .rst      (rst),
        .rd_addr  (csr_req.id),
        .rd_data  (rd_data),
        .rd_hit   (rd_hit),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .trap_upd (trap_upd),
        .view     (view)
    );

    trap_unit u_trap (
        .clk            (clk),
        .rst            (rst),
        .trap_valid     (trap_valid),
        .trap_req       (trap_req),
        .view           (view),
        .trap_upd       (trap_upd),
        .redirect_valid (redirect_valid),
        .target_pc      (target_pc),
        .mode           (mode)
    );

endmodule

// ==== test/csr_properties.sv ====
`timescale 1ns/10ps

module csr_properties (
    input logic           clk,
    input logic           rst,
    input logic           csr_valid,
    input logic           trap_valid,
    input logic           resp_valid,
    input logic           redirect_valid,
    input csr_pkg::priv_t mode
);
    import csr_pkg::*;

    // the two request paths never share a cycle
    strobe_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(csr_valid && trap_valid))
        else $error("csr_valid and trap_valid high in the same cycle");

    resp_follows: assert property (@(posedge clk) disable iff (rst) csr_valid |=> resp_valid)
        else $error("csr request not answered in the next cycle");

    resp_caused: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> $past(csr_valid))
        else $error("response strobe without a csr request one cycle earlier");

    redirect_follows: assert property (@(posedge clk) disable iff (rst)
        trap_valid |=> redirect_valid)
        else $error("trap request not redirected in the next cycle");

    redirect_caused: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |-> $past(trap_valid))
        else $error("redirect strobe without a trap request one cycle earlier");

    mode_legal: assert property (@(posedge clk) disable iff (rst)
        (mode == priv_u) || (mode == priv_s) || (mode == priv_m))
        else $error("privilege mode holds the reserved value 2");

endmodule

bind csr_top csr_properties u_props (
    .clk            (clk),
    .rst            (rst),
    .csr_valid      (csr_valid),
    .trap_valid     (trap_valid),
    .resp_valid     (resp_valid),
    .redirect_valid (redirect_valid),
    .mode           (mode)
);

// ==== test/csr_tb.sv ====
`timescale 1ns/10ps

module csr_tb;
    import csr_pkg::*;

    localparam logic [31:0] misa_cfg = 32'h4014_0100;
    // sie 1, mie 3, spie 5, mpie 7, spp 8, mpp 12:11, tsr 22
    localparam logic [31:0] m_status_bits = 32'h0040_19aa;
    localparam logic [31:0] s_status_bits = 32'h0000_0122;
    localparam int sie_b = 1;
    localparam int mie_b = 3;
    localparam int spie_b = 5;
    localparam int mpie_b = 7;
    localparam int spp_b = 8;
    localparam int tsr_b = 22;
    localparam int timeout_cycles = 10;
    localparam int random_ops = 3000;
    localparam csr_addr_t addr_list [12] = '{addr_sstatus, addr_stvec, addr_sscratch,
        addr_sepc, addr_scause, addr_mstatus, addr_misa, addr_medeleg, addr_mtvec,
        addr_mscratch, addr_mepc, addr_mcause};

    logic        clk;
    logic        rst;
    logic        csr_valid;
    csr_req_t    csr_req;
    logic        trap_valid;
    trap_req_t   trap_req;
    logic        resp_valid;
    csr_resp_t   resp;
    logic        redirect_valid;
    logic [31:0] target_pc;
    priv_t       mode;

    logic [31:0] lcg_state;
    int          errors;
    int          timeouts;

    // reference model state
    logic [31:0] ref_status;
    logic [31:0] ref_medeleg;
    logic [31:0] ref_mtvec;
    logic [31:0] ref_mscratch;
    logic [31:0] ref_mepc;
    logic [31:0] ref_mcause;
    logic [31:0] ref_stvec;
    logic [31:0] ref_sscratch;
    logic [31:0] ref_sepc;
    logic [31:0] ref_scause;
    priv_t       ref_mode;

    csr_top #(
        .misa_value (misa_cfg)
    ) csr_top_inst (
        .clk            (clk),
        .rst            (rst),
        .csr_valid      (csr_valid),
        .csr_req        (csr_req),
        .trap_valid     (trap_valid),
        .trap_req       (trap_req),
        .resp_valid     (resp_valid),
        .resp           (resp),
        .redirect_valid (redirect_valid),
        .target_pc      (target_pc),
        .mode           (mode)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] read_model(input csr_addr_t addr, output logic hit);
        hit = 1'b1;
        case (addr)
            addr_sstatus:  return ref_status & s_status_bits;
            addr_stvec:    return ref_stvec;
            addr_sscratch: return ref_sscratch;
            addr_sepc:     return ref_sepc;
            addr_scause:   return ref_scause;
            addr_mstatus:  return ref_status;
            addr_misa:     return misa_cfg;
            addr_medeleg:  return ref_medeleg;
            addr_mtvec:    return ref_mtvec;
            addr_mscratch: return ref_mscratch;
            addr_mepc:     return ref_mepc;
            addr_mcause:   return ref_mcause;
            default: begin
                hit = 1'b0;
                return 32'd0;
            end
        endcase
    endfunction

    function automatic void apply_write(input csr_addr_t addr, input logic [31:0] value);
        logic [31:0] st;
        case (addr)
            addr_sstatus: ref_status = (ref_status & ~s_status_bits) | (value & s_status_bits);
            addr_mstatus: begin
                st = value & m_status_bits;
                // mpp holds its old value when the reserved mode 2 is written
                if (st[12:11] == 2'b10) begin
                    st[12:11] = ref_status[12:11];
                end
                ref_status = st;
            end
            addr_medeleg:  ref_medeleg = value & 32'h0000_ffff;
            addr_mtvec:    ref_mtvec = value & ~32'h3;
            addr_mscratch: ref_mscratch = value;
            addr_mepc:     ref_mepc = value & ~32'h3;
            addr_mcause:   ref_mcause = value & 32'h1f;
            addr_stvec:    ref_stvec = value & ~32'h3;
            addr_sscratch: ref_sscratch = value;
            addr_sepc:     ref_sepc = value & ~32'h3;
            addr_scause:   ref_scause = value & 32'h1f;
            default: ;
        endcase
    endfunction

    task automatic issue_csr(input csr_op_t op, input logic use_imm, input logic [4:0] imm,
                             input logic [31:0] src, input csr_addr_t addr);
        logic [31:0] operand;
        logic [31:0] old_value;
        logic        hit;
        logic        writes;
        logic        bad;
        int          n;
        operand = use_imm ? {27'd0, imm} : src;
        old_value = read_model(addr, hit);
        writes = (op == op_rw) || (operand != 32'd0);
        bad = !hit || (ref_mode < addr[9:8]) ||
              (writes && (addr[11:10] == 2'b11 || addr == addr_misa));
        csr_req.op = op;
        csr_req.use_imm = use_imm;
        csr_req.imm = imm;
        csr_req.src = src;
        csr_req.id = addr;
        csr_valid = 1'b1;
        @(negedge clk);
        csr_valid = 1'b0;
        n = 1;
        while (!resp_valid && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!resp_valid) begin
            $display("no csr response within %0d cycles at %0t", timeout_cycles, $time);
            timeouts++;
        end else begin
            assert (n == 1) else begin
                $display("csr response arrived %0d cycles after the request", n);
                errors++;
            end
            compare_word("resp.illegal", {31'd0, resp.illegal}, {31'd0, bad});
            compare_word("resp.rdata", resp.rdata, bad ? 32'd0 : old_value);
            compare_word("mode", {30'd0, mode}, {30'd0, ref_mode});
        end
        if (!bad && writes) begin
            case (op)
                op_rw:   apply_write(addr, operand);
                op_rs:   apply_write(addr, old_value | operand);
                default: apply_write(addr, old_value & ~operand);
            endcase
        end
    endtask

    task automatic take_trap(input logic [4:0] code, input logic [31:0] pc);
        logic        ret_m;
        logic        ret_s;
        logic        ret_ok;
        logic [4:0]  cause;
        priv_t       exp_mode;
        logic [31:0] exp_pc;
        int          n;
        ret_m = code == exc_mret;
        ret_s = code == exc_sret;
        ret_ok = (ret_m && ref_mode == priv_m) ||
                 (ret_s && (ref_mode == priv_m ||
                            (ref_mode == priv_s && !ref_status[tsr_b])));
        if (ret_ok && ret_m) begin
            exp_mode = ref_status[12:11];
            exp_pc = ref_mepc;
            ref_status[mie_b] = ref_status[mpie_b];
            ref_status[mpie_b] = 1'b1;
            ref_status[12:11] = priv_u;
        end else if (ret_ok) begin
            exp_mode = {1'b0, ref_status[spp_b]};
            exp_pc = ref_sepc;
            ref_status[sie_b] = ref_status[spie_b];
            ref_status[spie_b] = 1'b1;
            ref_status[spp_b] = 1'b0;
        end else begin
            if (code == exc_ecall) begin
                cause = exc_ecall + {3'd0, ref_mode};
            end else if (ret_m || ret_s) begin
                cause = exc_illegal;
            end else begin
                cause = code;
            end
            if (ref_mode != priv_m && ref_medeleg[cause]) begin
                exp_mode = priv_s;
                exp_pc = ref_stvec;
                ref_status[spp_b] = ref_mode[0];
                ref_status[spie_b] = ref_status[sie_b];
                ref_status[sie_b] = 1'b0;
                ref_sepc = pc & ~32'h3;
                ref_scause = {27'd0, cause};
            end else begin
                exp_mode = priv_m;
                exp_pc = ref_mtvec;
                ref_status[12:11] = ref_mode;
                ref_status[mpie_b] = ref_status[mie_b];
                ref_status[mie_b] = 1'b0;
                ref_mepc = pc & ~32'h3;
                ref_mcause = {27'd0, cause};
            end
        end
        ref_mode = exp_mode;
        trap_req.code = code;
        trap_req.pc = pc;
        trap_valid = 1'b1;
        @(negedge clk);
        trap_valid = 1'b0;
        n = 1;
        while (!redirect_valid && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!redirect_valid) begin
            $display("no redirect within %0d cycles at %0t", timeout_cycles, $time);
            timeouts++;
        end else begin
            assert (n == 1) else begin
                $display("redirect arrived %0d cycles after the trap request", n);
                errors++;
            end
            compare_word("target_pc", target_pc, exp_pc);
            compare_word("mode", {30'd0, mode}, {30'd0, exp_mode});
        end
    endtask

    initial begin
        int          i;
        int          idx;
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] src;
        logic [4:0]  code;
        csr_addr_t   addr;
        csr_op_t     op;
        rst = 1'b1;
        csr_valid = 1'b0;
        csr_req = '0;
        trap_valid = 1'b0;
        trap_req = '0;
        lcg_state = 32'd34;
        errors = 0;
        timeouts = 0;
        ref_status = '0;
        ref_medeleg = '0;
        ref_mtvec = '0;
        ref_mscratch = '0;
        ref_mepc = '0;
        ref_mcause = '0;
        ref_stvec = '0;
        ref_sscratch = '0;
        ref_sepc = '0;
        ref_scause = '0;
        ref_mode = priv_m;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compare_word("mode", {30'd0, mode}, {30'd0, priv_m});
        // every register read once straight out of reset
        for (i = 0; i < 12; i++) begin
            issue_csr(op_rs, 1'b0, 5'd0, 32'd0, addr_list[i]);
        end
        issue_csr(op_rw, 1'b0, 5'd0, 32'hffff_ffff, addr_misa);
        issue_csr(op_rs, 1'b1, 5'd3, 32'd0, 12'h7c0);
        for (i = 0; i < random_ops && timeouts == 0; i++) begin
            r = next_random();
            if (r[31:30] == 2'b00) begin
                r2 = next_random();
                case (r2[31:30])
                    2'd0:    code = exc_mret;
                    2'd1:    code = exc_sret;
                    2'd2:    code = exc_ecall;
                    default: code = r2[4:0];
                endcase
                take_trap(code, next_random());
            end else begin
                idx = int'(r[27:24]) % 12;
                addr = (r[29:28] != 2'b00) ? addr_list[idx] : r[11:0];
                case (r[23:22])
                    2'd1:    op = op_rs;
                    2'd2:    op = op_rc;
                    default: op = op_rw;
                endcase
                src = (r[21:20] == 2'b00) ? 32'd0 : next_random();
                issue_csr(op, r[19], r[18:14], src, addr);
                // read back what was just written
                if (r[13]) begin
                    issue_csr(op_rs, 1'b0, 5'd0, 32'd0, addr);
                end
            end
            if (r[12] && r[11]) begin
                @(negedge clk);
            end
        end
        $display("checks done with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/csr_pkg.sv
logic/csr_access.sv
logic/csr_file.sv
logic/trap_unit.sv
logic/csr_top.sv
test/csr_properties.sv
test/csr_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the csr testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f vlog.f --top-module csr_tb -o csr_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/csr_sim)
run_status=$?
echo "$out"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
